/* alu_defines.svh */
////////////////////
// datapath widths for the rv32 alu
// the bit-count and byte logic assume 32 bits made of 8-bit bytes
////////////////////

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// register width
`define ALU_XLEN    32

// shift amount, log2 of the width
`define ALU_SHAMT_W 5

// count result, one bit wider so 32 fits
`define ALU_CNT_W   6

// byte width for orc.b, rev8 and sext
`define ALU_BYTE_W  8

`endif

/* alu_pkg.sv */
////////////////////
// shared types of the alu
// opcode values are local to this design, not the isa funct fields
////////////////////

`include "alu_defines.svh"

package alu_pkg;

  // one datapath word
  typedef logic [`ALU_XLEN-1:0] alu_word_t;

  // kept operations only, rotate and single-bit ops are gone
  typedef enum logic [5:0] {
    // adder
    ALU_ADD      = 6'h00,
    ALU_SUB      = 6'h01,
    ALU_B_SH1ADD = 6'h02,
    ALU_B_SH2ADD = 6'h03,
    ALU_B_SH3ADD = 6'h04,
    // bitwise logic
    ALU_AND      = 6'h08,
    ALU_OR       = 6'h09,
    ALU_XOR      = 6'h0a,
    ALU_B_ANDN   = 6'h0b,
    ALU_B_ORN    = 6'h0c,
    ALU_B_XNOR   = 6'h0d,
    // shifts
    ALU_SLL      = 6'h10,
    ALU_SRL      = 6'h11,
    ALU_SRA      = 6'h12,
    // compares, flag and set forms
    ALU_EQ       = 6'h18,
    ALU_NE       = 6'h19,
    ALU_GES      = 6'h1a,
    ALU_GEU      = 6'h1b,
    ALU_LTS      = 6'h1c,
    ALU_LTU      = 6'h1d,
    ALU_SLTS     = 6'h1e,
    ALU_SLTU     = 6'h1f,
    // zbb counts
    ALU_B_CLZ    = 6'h20,
    ALU_B_CTZ    = 6'h21,
    ALU_B_CPOP   = 6'h22,
    // zbb min and max
    ALU_B_MIN    = 6'h28,
    ALU_B_MINU   = 6'h29,
    ALU_B_MAX    = 6'h2a,
    ALU_B_MAXU   = 6'h2b,
    // zbb byte ops
    ALU_B_ORC_B  = 6'h30,
    ALU_B_REV8   = 6'h31,
    ALU_B_SEXT_B = 6'h32,
    ALU_B_SEXT_H = 6'h33
  } alu_opcode_e;

endpackage

/* alu_adder.sv */
////////////////////
// shared adder for add, sub and shNadd
// purely combinational, carry out is dropped
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_adder (
  input  alu_pkg::alu_opcode_e operator_i,
  input  alu_pkg::alu_word_t   operand_a_i,
  input  alu_pkg::alu_word_t   operand_b_i,
  output alu_pkg::alu_word_t   sum_o
);

  import alu_pkg::*;

  logic                negate_b;
  alu_word_t           op_a_pre;
  alu_word_t           op_b_sel;
  logic [`ALU_XLEN:0]  in_a;
  logic [`ALU_XLEN:0]  in_b;
  logic [`ALU_XLEN:0]  sum_ext;

  // only sub takes two's complement of b
  assign negate_b = (operator_i == ALU_SUB);
  assign op_b_sel = negate_b ? ~operand_b_i : operand_b_i;

  // pre-shift of a for the zba adds
  always_comb begin
    case (operator_i)
      ALU_B_SH1ADD: op_a_pre = operand_a_i << 1;
      ALU_B_SH2ADD: op_a_pre = operand_a_i << 2;
      ALU_B_SH3ADD: op_a_pre = operand_a_i << 3;
      default:      op_a_pre = operand_a_i;
    endcase
  end

  // extra low bit carries the +1 of the negation
  assign in_a = {op_a_pre, 1'b1};
  assign in_b = {op_b_sel, negate_b};

  assign sum_ext = in_a + in_b;

  // drop the carry lane
  assign sum_o = sum_ext[`ALU_XLEN:1];

endmodule

/* alu_shifter.sv */
////////////////////
// 32-bit barrel shifter, sll, srl and sra
// divider request wins over operator_i and always shifts left
// amount is taken modulo 32
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_shifter (
  input  alu_pkg::alu_opcode_e     operator_i,
  input  alu_pkg::alu_word_t       operand_a_i,
  input  alu_pkg::alu_word_t       operand_b_i,
  input  logic                     div_shift_en_i,
  input  logic [`ALU_SHAMT_W-1:0]  div_shift_amt_i,
  output alu_pkg::alu_word_t       shift_o
);

  import alu_pkg::*;

  logic                      shift_right;
  logic                      fill_bit;
  logic [`ALU_SHAMT_W-1:0]   shamt;
  logic [`ALU_SHAMT_W-1:0]   stage_amt;
  logic [2*`ALU_XLEN-1:0]    feed;
  logic [2*`ALU_XLEN-1:0]    tmp;

  ////////////////////
  // direction decode
  ////////////////////

  always_comb begin
    shift_right = 1'b0;
    fill_bit    = 1'b0;
    // divider path is a plain left shift
    if (!div_shift_en_i) begin
      case (operator_i)
        ALU_SRL: shift_right = 1'b1;
        ALU_SRA: begin
          shift_right = 1'b1;
          fill_bit    = operand_a_i[`ALU_XLEN-1];
        end
        default: ;
      endcase
    end
  end

  // amount source, divider first
  assign shamt = div_shift_en_i ? div_shift_amt_i : operand_b_i[`ALU_SHAMT_W-1:0];

  // right shift by s is a left shift by ~s = 31-s,
  // the one spare zero at the bottom of the feed makes up the missing 1
  assign stage_amt = shift_right ? ~shamt : shamt;

  // two-word feed, result is read from the upper word
  //   left:  a on top, zeros below
  //   right: fill on top, a one bit above the bottom
  assign feed = shift_right ?
                {{(`ALU_XLEN-1){fill_bit}}, operand_a_i, 1'b0} :
                {operand_a_i, {`ALU_XLEN{1'b0}}};

  ////////////////////
  // log shifter
  ////////////////////

  // one mux stage per amount bit
  always_comb begin
    tmp = feed;
    tmp = stage_amt[4] ? (tmp << 16) : tmp;
    tmp = stage_amt[3] ? (tmp << 8)  : tmp;
    tmp = stage_amt[2] ? (tmp << 4)  : tmp;
    tmp = stage_amt[1] ? (tmp << 2)  : tmp;
    tmp = stage_amt[0] ? (tmp << 1)  : tmp;
  end

  // upper word holds the shifted value
  assign shift_o = tmp[2*`ALU_XLEN-1:`ALU_XLEN];

endmodule

/* alu_compare.sv */
////////////////////
// compare unit, flag plus min and max pick
// flag only meaningful for eq..sltu, else it shows a == b
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_compare (
  input  alu_pkg::alu_opcode_e operator_i,
  input  alu_pkg::alu_word_t   operand_a_i,
  input  alu_pkg::alu_word_t   operand_b_i,
  output logic                 cmp_flag_o,
  output alu_pkg::alu_word_t   minmax_o
);

  import alu_pkg::*;

  logic cmp_signed;
  logic is_equal;
  logic is_greater;
  logic is_max;
  logic take_a;

  // signed forms, min and max included
  assign cmp_signed = operator_i inside {ALU_GES, ALU_LTS, ALU_SLTS, ALU_B_MIN, ALU_B_MAX};

  assign is_equal = (operand_a_i == operand_b_i);

  // 33-bit signed compare covers both forms,
  // top bit is the sign only for signed ops
  assign is_greater =
    $signed({operand_a_i[`ALU_XLEN-1] & cmp_signed, operand_a_i}) >
    $signed({operand_b_i[`ALU_XLEN-1] & cmp_signed, operand_b_i});

  ////////////////////
  // flag
  ////////////////////

  always_comb begin
    cmp_flag_o = is_equal;
    case (operator_i)
      ALU_EQ:             cmp_flag_o = is_equal;
      ALU_NE:             cmp_flag_o = ~is_equal;
      ALU_GES, ALU_GEU:   cmp_flag_o = is_greater | is_equal;
      ALU_LTS, ALU_SLTS,
      ALU_LTU, ALU_SLTU:  cmp_flag_o = ~(is_greater | is_equal);
      default: ;
    endcase
  end

  ////////////////////
  // min / max
  ////////////////////

  assign is_max = (operator_i == ALU_B_MAX) || (operator_i == ALU_B_MAXU);

  // max keeps a when greater, min keeps a when not greater
  // ties give b, same value anyway
  assign take_a = is_max ? is_greater : ~(is_greater | is_equal);

  assign minmax_o = take_a ? operand_a_i : operand_b_i;

endmodule

/* alu_bitcount.sv */
////////////////////
// clz / ctz and cpop
// divider clz request overrides the opcode
// an all-zero word counts as 32
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_bitcount (
  input  alu_pkg::alu_opcode_e    operator_i,
  input  alu_pkg::alu_word_t      operand_a_i,
  input  logic                    div_clz_en_i,
  input  alu_pkg::alu_word_t      div_clz_data_i,
  output logic [`ALU_CNT_W-1:0]   zero_cnt_o,
  output logic [`ALU_CNT_W-1:0]   pop_cnt_o
);

  import alu_pkg::*;

  alu_word_t                 src_word;
  alu_word_t                 src_rev;
  alu_word_t                 search_word;
  logic                      ctz_mode;
  logic                      no_one;
  logic [`ALU_SHAMT_W-1:0]   first_idx;

  ////////////////////
  // source select
  ////////////////////

  // divider first
  assign src_word = div_clz_en_i ? div_clz_data_i : operand_a_i;

  // trailing count only for ctz without a divider request
  assign ctz_mode = !div_clz_en_i && (operator_i == ALU_B_CTZ);

  // bit reverse, turns leading zeros into trailing zeros
  for (genvar k = 0; k < `ALU_XLEN; k++) begin : gen_src_rev
    assign src_rev[k] = src_word[`ALU_XLEN-1-k];
  end

  assign search_word = ctz_mode ? src_word : src_rev;

  ////////////////////
  // first-one search
  ////////////////////

  // scan down, lowest set bit is written last and wins
  always_comb begin
    first_idx = '0;
    for (int i = `ALU_XLEN-1; i >= 0; i--) begin
      if (search_word[i]) begin
        first_idx = `ALU_SHAMT_W'(i);
      end
    end
  end

  assign no_one = ~|search_word;

  assign zero_cnt_o = no_one ? `ALU_CNT_W'(`ALU_XLEN) : {1'b0, first_idx};

  // population count, always on operand a
  always_comb begin
    pop_cnt_o = '0;
    for (int j = 0; j < `ALU_XLEN; j++) begin
      pop_cnt_o = pop_cnt_o + `ALU_CNT_W'(operand_a_i[j]);
    end
  end

endmodule

/* alu.sv */
////////////////////
// rv32 integer and zba/zbb alu, fully combinational
// no rotates and no single-bit ops
// div_* ports lend the shifter and clz to a divider
// unlisted opcode gives result 0
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu (
  input  alu_pkg::alu_opcode_e     operator_i,
  input  alu_pkg::alu_word_t       operand_a_i,
  input  alu_pkg::alu_word_t       operand_b_i,

  // divider towards shifter
  input  logic                     div_shift_en_i,
  input  logic [`ALU_SHAMT_W-1:0]  div_shift_amt_i,

  // divider towards clz
  input  logic                     div_clz_en_i,
  input  alu_pkg::alu_word_t       div_clz_data_i,

  output alu_pkg::alu_word_t       result_o,
  output logic                     comparison_result_o,
  output alu_pkg::alu_word_t       div_op_a_shifted_o,
  output logic [`ALU_CNT_W-1:0]    div_clz_result_o
);

  import alu_pkg::*;

  alu_word_t                sum;
  alu_word_t                shift_result;
  alu_word_t                minmax;
  logic                     cmp_flag;
  logic [`ALU_CNT_W-1:0]    zero_cnt;
  logic [`ALU_CNT_W-1:0]    pop_cnt;
  alu_word_t                orc_b;
  alu_word_t                rev8;
  alu_word_t                sext_b;
  alu_word_t                sext_h;

  ////////////////////
  // units
  ////////////////////

  alu_adder u_adder (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sum_o       (sum)
  );

  alu_shifter u_shifter (
    .operator_i      (operator_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .div_shift_en_i  (div_shift_en_i),
    .div_shift_amt_i (div_shift_amt_i),
    .shift_o         (shift_result)
  );

  alu_compare u_compare (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .cmp_flag_o  (cmp_flag),
    .minmax_o    (minmax)
  );

  alu_bitcount u_bitcount (
    .operator_i     (operator_i),
    .operand_a_i    (operand_a_i),
    .div_clz_en_i   (div_clz_en_i),
    .div_clz_data_i (div_clz_data_i),
    .zero_cnt_o     (zero_cnt),
    .pop_cnt_o      (pop_cnt)
  );

  // divider side outputs
  assign div_op_a_shifted_o  = shift_result;
  assign div_clz_result_o    = zero_cnt;
  assign comparison_result_o = cmp_flag;

  ////////////////////
  // byte ops
  ////////////////////

  // orc.b smears each byte, rev8 swaps byte order
  for (genvar i = 0; i < `ALU_XLEN/`ALU_BYTE_W; i++) begin : gen_byte
    assign orc_b[i*`ALU_BYTE_W +: `ALU_BYTE_W] =
      {`ALU_BYTE_W{|operand_a_i[i*`ALU_BYTE_W +: `ALU_BYTE_W]}};
    assign rev8[i*`ALU_BYTE_W +: `ALU_BYTE_W] =
      operand_a_i[(`ALU_XLEN/`ALU_BYTE_W-1-i)*`ALU_BYTE_W +: `ALU_BYTE_W];
  end

  // sign extend low byte and low half
  assign sext_b = {{(`ALU_XLEN-`ALU_BYTE_W){operand_a_i[`ALU_BYTE_W-1]}},
                   operand_a_i[`ALU_BYTE_W-1:0]};
  assign sext_h = {{(`ALU_XLEN-2*`ALU_BYTE_W){operand_a_i[2*`ALU_BYTE_W-1]}},
                   operand_a_i[2*`ALU_BYTE_W-1:0]};

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      // logic
      ALU_AND:    result_o = operand_a_i & operand_b_i;
      ALU_OR:     result_o = operand_a_i | operand_b_i;
      ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      ALU_B_ANDN: result_o = operand_a_i & ~operand_b_i;
      ALU_B_ORN:  result_o = operand_a_i | ~operand_b_i;
      ALU_B_XNOR: result_o = operand_a_i ^ ~operand_b_i;

      // adder, sub and shNadd share it
      ALU_ADD, ALU_SUB,
      ALU_B_SH1ADD, ALU_B_SH2ADD, ALU_B_SH3ADD: result_o = sum;

      // shifts
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;

      // set-less-than, flag in bit 0
      ALU_SLTS, ALU_SLTU: result_o = {{(`ALU_XLEN-1){1'b0}}, cmp_flag};

      // counts, zero extended
      ALU_B_CLZ, ALU_B_CTZ: result_o = {{(`ALU_XLEN-`ALU_CNT_W){1'b0}}, zero_cnt};
      ALU_B_CPOP:           result_o = {{(`ALU_XLEN-`ALU_CNT_W){1'b0}}, pop_cnt};

      // min and max
      ALU_B_MIN, ALU_B_MINU,
      ALU_B_MAX, ALU_B_MAXU: result_o = minmax;

      // byte ops
      ALU_B_ORC_B:  result_o = orc_b;
      ALU_B_REV8:   result_o = rev8;
      ALU_B_SEXT_B: result_o = sext_b;
      ALU_B_SEXT_H: result_o = sext_h;

      default: ;
    endcase
  end

endmodule

/* tb_alu_ref.svh */
////////////////////
// reference model of the alu, written from the isa rules
// needs alu_pkg imported and alu_defines.svh seen before inclusion
////////////////////

`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

// leading zeros, 32 for an empty word
function automatic logic [`ALU_CNT_W-1:0] lead_zeros(input alu_word_t w);
  logic [`ALU_CNT_W-1:0] n;
  n = `ALU_CNT_W'(`ALU_XLEN);
  for (int i = 0; i < `ALU_XLEN; i++) begin
    if (w[i]) begin
      n = `ALU_CNT_W'(`ALU_XLEN - 1 - i);
    end
  end
  return n;
endfunction

// trailing zeros, 32 for an empty word
function automatic logic [`ALU_CNT_W-1:0] trail_zeros(input alu_word_t w);
  logic [`ALU_CNT_W-1:0] n;
  n = `ALU_CNT_W'(`ALU_XLEN);
  for (int i = `ALU_XLEN - 1; i >= 0; i--) begin
    if (w[i]) begin
      n = `ALU_CNT_W'(i);
    end
  end
  return n;
endfunction

// expected result, flag and both divider outputs
function automatic void alu_ref(
  input  alu_opcode_e              op,
  input  alu_word_t                a,
  input  alu_word_t                b,
  input  logic                     sh_en,
  input  logic [`ALU_SHAMT_W-1:0]  sh_amt,
  input  logic                     clz_en,
  input  alu_word_t                clz_data,
  output alu_word_t                res,
  output logic                     flag,
  output alu_word_t                shifted,
  output logic [`ALU_CNT_W-1:0]    cnt
);
  logic lt_s;
  logic lt_u;
  lt_s = $signed(a) < $signed(b);
  lt_u = a < b;

  // shifter, divider request always shifts left
  if (sh_en) begin
    shifted = a << sh_amt;
  end else if (op == ALU_SRL) begin
    shifted = a >> b[4:0];
  end else if (op == ALU_SRA) begin
    shifted = $signed(a) >>> b[4:0];
  end else begin
    shifted = a << b[4:0];
  end

  // zero count, divider request counts leading zeros
  if (clz_en) begin
    cnt = lead_zeros(clz_data);
  end else if (op == ALU_B_CTZ) begin
    cnt = trail_zeros(a);
  end else begin
    cnt = lead_zeros(a);
  end

  // flag, plain equality outside the compares
  case (op)
    ALU_NE:            flag = (a != b);
    ALU_GES:           flag = !lt_s;
    ALU_GEU:           flag = !lt_u;
    ALU_LTS, ALU_SLTS: flag = lt_s;
    ALU_LTU, ALU_SLTU: flag = lt_u;
    default:           flag = (a == b);
  endcase

  res = '0;
  case (op)
    ALU_ADD:      res = a + b;
    ALU_SUB:      res = a - b;
    ALU_B_SH1ADD: res = (a << 1) + b;
    ALU_B_SH2ADD: res = (a << 2) + b;
    ALU_B_SH3ADD: res = (a << 3) + b;
    ALU_AND:      res = a & b;
    ALU_OR:       res = a | b;
    ALU_XOR:      res = a ^ b;
    ALU_B_ANDN:   res = a & ~b;
    ALU_B_ORN:    res = a | ~b;
    ALU_B_XNOR:   res = ~(a ^ b);
    ALU_SLL, ALU_SRL, ALU_SRA: res = shifted;
    ALU_SLTS, ALU_SLTU:        res = {{(`ALU_XLEN-1){1'b0}}, flag};
    ALU_B_CLZ, ALU_B_CTZ:      res = {{(`ALU_XLEN-`ALU_CNT_W){1'b0}}, cnt};
    ALU_B_CPOP:   res = 32'($countones(a));
    ALU_B_MIN:    res = lt_s ? a : b;
    ALU_B_MINU:   res = lt_u ? a : b;
    ALU_B_MAX:    res = lt_s ? b : a;
    ALU_B_MAXU:   res = lt_u ? b : a;
    ALU_B_ORC_B: begin
      for (int k = 0; k < 4; k++) begin
        res[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
    end
    ALU_B_REV8:   res = {a[7:0], a[15:8], a[23:16], a[31:24]};
    ALU_B_SEXT_B: res = 32'($signed(a[7:0]));
    ALU_B_SEXT_H: res = 32'($signed(a[15:0]));
    default:      res = '0;
  endcase
endfunction

`endif

/* tb_alu.sv */
////////////////////
// self-checking testbench for the alu
// inputs change on the falling edge, outputs checked on the next rising edge
// clock and reset only pace the stimulus, the dut has neither
////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module tb_alu;

  import alu_pkg::*;

  `include "tb_alu_ref.svh"

  localparam int CLK_NS       = 10;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS    = 6;
  localparam int N_ARITH      = 400;
  localparam int N_SHIFT_RND  = 100;
  localparam int N_SHIFT      = 32 * 3 * 2 + N_SHIFT_RND;
  localparam int N_CMP_RND    = 200;
  localparam int N_CMP        = 6 * 6 * 12 + N_CMP_RND;
  localparam int N_CNT_RND    = 150;
  localparam int N_CNT        = 34 * 3 + N_CNT_RND;
  localparam int N_BYTE       = 200;
  localparam int N_DIV_RND    = 300;
  localparam int N_DIV        = N_DIV_RND + 32;
  localparam int TOTAL_VECS   = N_ARITH + N_SHIFT + N_CMP + N_CNT + N_BYTE + N_DIV;
  // one cycle per vector, one per test end, reset, then slack
  localparam int WATCHDOG_NS  = (TOTAL_VECS + NUM_TESTS + RESET_CYCLES + 50) * CLK_NS;

  logic                     clk;
  logic                     rst_n_i;
  alu_opcode_e              operator_i;
  alu_word_t                operand_a_i;
  alu_word_t                operand_b_i;
  logic                     div_shift_en_i;
  logic [`ALU_SHAMT_W-1:0]  div_shift_amt_i;
  logic                     div_clz_en_i;
  alu_word_t                div_clz_data_i;
  alu_word_t                result_o;
  logic                     comparison_result_o;
  alu_word_t                div_op_a_shifted_o;
  logic [`ALU_CNT_W-1:0]    div_clz_result_o;

  // expected values, filled by the compare process
  alu_word_t                exp_res;
  logic                     exp_flag;
  alu_word_t                exp_shift;
  logic [`ALU_CNT_W-1:0]    exp_cnt;

  logic        check_en;
  string       cur_test;
  int          test_vecs;
  int          test_errs;
  int          total_vecs;
  int          total_errs;
  int          tests_failed;
  logic [31:0] rng_state;
  alu_opcode_e op_all[$];

  alu_opcode_e arith_ops [12] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_B_ANDN,
                                  ALU_B_ORN, ALU_B_XNOR, ALU_B_SH1ADD, ALU_B_SH2ADD,
                                  ALU_B_SH3ADD, ALU_ADD};
  alu_opcode_e shift_ops [3]  = '{ALU_SLL, ALU_SRL, ALU_SRA};
  alu_opcode_e cmp_ops [12]   = '{ALU_EQ, ALU_NE, ALU_GES, ALU_GEU, ALU_LTS, ALU_LTU,
                                  ALU_SLTS, ALU_SLTU, ALU_B_MIN, ALU_B_MINU, ALU_B_MAX,
                                  ALU_B_MAXU};
  alu_opcode_e count_ops [3]  = '{ALU_B_CLZ, ALU_B_CTZ, ALU_B_CPOP};
  alu_opcode_e byte_ops [4]   = '{ALU_B_ORC_B, ALU_B_REV8, ALU_B_SEXT_B, ALU_B_SEXT_H};
  // sign boundary operands
  alu_word_t   edge_vals [6]  = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                                  32'h8000_0000, 32'h8000_0001, 32'hffff_ffff};

  alu dut0 (
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .div_shift_en_i      (div_shift_en_i),
    .div_shift_amt_i     (div_shift_amt_i),
    .div_clz_en_i        (div_clz_en_i),
    .div_clz_data_i      (div_clz_data_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .div_op_a_shifted_o  (div_op_a_shifted_o),
    .div_clz_result_o    (div_clz_result_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  // xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int pick_idx(input int n);
    return int'(rand32() % 32'(n));
  endfunction

  // bytes are zero, top bit set or random
  function automatic alu_word_t byte_mix_word();
    alu_word_t   w;
    logic [31:0] r;
    for (int k = 0; k < 4; k++) begin
      r = rand32();
      case (r[9:8])
        2'd0:    w[8*k +: 8] = 8'h00;
        2'd1:    w[8*k +: 8] = {1'b1, r[6:0]};
        default: w[8*k +: 8] = r[7:0];
      endcase
    end
    return w;
  endfunction

  task automatic drive_vector(input alu_opcode_e op, input alu_word_t a, input alu_word_t b,
                              input logic se, input logic [`ALU_SHAMT_W-1:0] samt,
                              input logic ce, input alu_word_t cdata);
    @(negedge clk);
    operator_i      = op;
    operand_a_i     = a;
    operand_b_i     = b;
    div_shift_en_i  = se;
    div_shift_amt_i = samt;
    div_clz_en_i    = ce;
    div_clz_data_i  = cdata;
    check_en        = 1'b1;
  endtask

  // divider enables low, its data still moves
  task automatic drive_op(input alu_opcode_e op, input alu_word_t a, input alu_word_t b);
    drive_vector(op, a, b, 1'b0, `ALU_SHAMT_W'(rand32()), 1'b0, rand32());
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_vecs = 0;
    test_errs = 0;
  endtask

  // one more edge so the last vector is checked
  task automatic finish_test();
    @(negedge clk);
    check_en = 1'b0;
    $display("done %s: %0d vectors, %0d errors", cur_test, test_vecs, test_errs);
    total_vecs = total_vecs + test_vecs;
    total_errs = total_errs + test_errs;
    if (test_errs != 0) begin
      tests_failed++;
    end
  endtask

  ////////////////////
  // compare process
  ////////////////////

  always @(posedge clk) begin
    if (rst_n_i && check_en) begin
      alu_ref(operator_i, operand_a_i, operand_b_i, div_shift_en_i, div_shift_amt_i,
              div_clz_en_i, div_clz_data_i, exp_res, exp_flag, exp_shift, exp_cnt);
      test_vecs++;
      if (result_o !== exp_res) begin
        $display("ERR %s result_o op %s expected %h actual %h",
                 cur_test, operator_i.name(), exp_res, result_o);
        test_errs++;
      end
      if (comparison_result_o !== exp_flag) begin
        $display("ERR %s comparison_result_o op %s expected %h actual %h",
                 cur_test, operator_i.name(), exp_flag, comparison_result_o);
        test_errs++;
      end
      if (div_op_a_shifted_o !== exp_shift) begin
        $display("ERR %s div_op_a_shifted_o expected %h actual %h",
                 cur_test, exp_shift, div_op_a_shifted_o);
        test_errs++;
      end
      if (div_clz_result_o !== exp_cnt) begin
        $display("ERR %s div_clz_result_o expected %h actual %h",
                 cur_test, exp_cnt, div_clz_result_o);
        test_errs++;
      end
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    alu_opcode_e op;
    logic [31:0] r;
    alu_word_t   a;
    rng_state       = 32'd33276;
    check_en        = 1'b0;
    total_vecs      = 0;
    total_errs      = 0;
    tests_failed    = 0;
    operator_i      = ALU_ADD;
    operand_a_i     = '0;
    operand_b_i     = '0;
    div_shift_en_i  = 1'b0;
    div_shift_amt_i = '0;
    div_clz_en_i    = 1'b0;
    div_clz_data_i  = '0;
    op = op.first();
    repeat (op.num()) begin
      op_all.push_back(op);
      op = op.next();
    end
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    start_test("logic_arith");
    repeat (N_ARITH) drive_op(arith_ops[pick_idx(12)], rand32(), rand32());
    finish_test();

    // every amount, with and without the sign bit of a
    start_test("shifts");
    for (int amt = 0; amt < 32; amt++) begin
      for (int k = 0; k < 3; k++) begin
        for (int neg = 0; neg < 2; neg++) begin
          a = (neg == 1) ? (rand32() | 32'h8000_0000) : rand32();
          drive_op(shift_ops[k], a, (rand32() & 32'hffff_ffe0) | 32'(amt));
        end
      end
    end
    repeat (N_SHIFT_RND) drive_op(shift_ops[pick_idx(3)], rand32(), rand32());
    finish_test();

    start_test("compare");
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        for (int k = 0; k < 12; k++) begin
          drive_op(cmp_ops[k], edge_vals[i], edge_vals[j]);
        end
      end
    end
    // a quarter of the pairs are equal
    repeat (N_CMP_RND) begin
      a = rand32();
      r = rand32();
      drive_op(cmp_ops[pick_idx(12)], a, (r[1:0] == 2'd0) ? a : rand32());
    end
    finish_test();

    start_test("counts");
    for (int k = 0; k < 3; k++) begin
      drive_op(count_ops[k], 32'h0000_0000, rand32());
      drive_op(count_ops[k], 32'hffff_ffff, rand32());
      for (int i = 0; i < 32; i++) begin
        drive_op(count_ops[k], 32'h1 << i, rand32());
      end
    end
    // random words thinned from the top
    repeat (N_CNT_RND) begin
      r = rand32();
      drive_op(count_ops[pick_idx(3)], rand32() >> r[4:0], rand32());
    end
    finish_test();

    start_test("byte_ops");
    repeat (N_BYTE) drive_op(byte_ops[pick_idx(4)], byte_mix_word(), rand32());
    finish_test();

    // both requests on, ctz opcode must not turn the divider count around
    start_test("divider_share");
    for (int i = 0; i < 32; i++) begin
      drive_vector(ALU_B_CTZ, rand32(), rand32(), 1'b1, `ALU_SHAMT_W'(i), 1'b1,
                   (32'h8000_0000 >> i) | (rand32() >> (i + 1)));
    end
    repeat (N_DIV_RND) begin
      r = rand32();
      drive_vector(op_all[pick_idx(op_all.size())], rand32(), rand32(), r[0], r[5:1],
                   r[6], rand32() >> r[11:7]);
    end
    finish_test();

    $display("tests %0d, failing tests %0d, vectors %0d, errors %0d",
             NUM_TESTS, tests_failed, total_vecs, total_errs);
    if (total_errs == 0 && total_vecs == TOTAL_VECS) begin
      $display("TEST PASSED");
    end else begin
      if (total_vecs != TOTAL_VECS) begin
        $display("checked %0d vectors but %0d were planned", total_vecs, TOTAL_VECS);
      end
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* alu.f */
+incdir+.
alu_pkg.sv
alu_adder.sv
alu_shifter.sv
alu_compare.sv
alu_bitcount.sv
alu.sv
tb_alu.sv

/* run_sim.sh */
#!/bin/sh
# builds the alu testbench with verilator and runs it
# exit status is non-zero unless the log holds the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_alu -Mdir obj_dir -f alu.f

./obj_dir/Vtb_alu > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure, see sim.log"
  exit 1
fi
